/* hdl/vic_types_pkg.sv */
package vic_types_pkg;

// ---------------------------------------------------------------------------
// chip standards and colour indices
// ---------------------------------------------------------------------------
typedef enum logic {
    CHIP_6567R8 = 1'b0,   // ntsc
    CHIP_6569   = 1'b1    // pal
} vic_chip_t;

typedef enum logic [3:0] {
    COL_BLACK       = 4'd0,
    COL_WHITE       = 4'd1,
    COL_RED         = 4'd2,
    COL_CYAN        = 4'd3,
    COL_PURPLE      = 4'd4,
    COL_GREEN       = 4'd5,
    COL_BLUE        = 4'd6,
    COL_YELLOW      = 4'd7,
    COL_ORANGE      = 4'd8,
    COL_BROWN       = 4'd9,
    COL_LIGHT_RED   = 4'd10,
    COL_DARK_GREY   = 4'd11,
    COL_GREY        = 4'd12,
    COL_LIGHT_GREEN = 4'd13,
    COL_LIGHT_BLUE  = 4'd14,
    COL_LIGHT_GREY  = 4'd15
} vic_color;

// class of the current raster line
typedef enum logic [1:0] {
    LINE_VISIBLE = 2'd0,
    LINE_BORDER  = 2'd1,  // blanked, no vertical sync
    LINE_VSYNC   = 2'd2
} line_phase_t;

endpackage : vic_types_pkg

/* hdl/vic_timing_pkg.sv */
package vic_timing_pkg;

// ---------------------------------------------------------------------------
// raster geometry per chip
// ---------------------------------------------------------------------------
localparam int DOTS_6567R8        = 520;  // dots per line
localparam int DOTS_6569          = 504;
localparam int LINES_6567R8       = 263;  // lines per frame
localparam int LINES_6569         = 312;
localparam int VIS_LINES_6567R8   = 234;  // lines below this are visible
localparam int VIS_LINES_6569     = 284;
localparam int VSYNC_START_6567R8 = 240;
localparam int VSYNC_START_6569   = 300;
localparam int VSYNC_LINES        = 3;

// horizontal, same for both chips
localparam int VIS_DOTS    = 384;
localparam int HSYNC_START = 400;
localparam int HSYNC_DOTS  = 40;
localparam int DOT_DIV     = 4;           // clk_dot4x cycles per dot

function automatic logic [9:0] dots_per_line(vic_types_pkg::vic_chip_t chip);
    return (chip == vic_types_pkg::CHIP_6569) ? 10'(DOTS_6569) : 10'(DOTS_6567R8);
endfunction

function automatic logic [8:0] lines_per_frame(vic_types_pkg::vic_chip_t chip);
    return (chip == vic_types_pkg::CHIP_6569) ? 9'(LINES_6569) : 9'(LINES_6567R8);
endfunction

function automatic logic [8:0] vis_lines(vic_types_pkg::vic_chip_t chip);
    return (chip == vic_types_pkg::CHIP_6569) ? 9'(VIS_LINES_6569) : 9'(VIS_LINES_6567R8);
endfunction

function automatic logic [8:0] vsync_start(vic_types_pkg::vic_chip_t chip);
    return (chip == vic_types_pkg::CHIP_6569) ? 9'(VSYNC_START_6569)
                                              : 9'(VSYNC_START_6567R8);
endfunction

endpackage : vic_timing_pkg

/* hdl/vic_timing_ctrl.sv */
`timescale 1ns/10ps

module vic_timing_ctrl (
    input  logic                       clk_dot4x,
    input  logic                       rst_n,
    input  vic_types_pkg::vic_chip_t   chip,
    output logic                       dot_en,       // 1 in 4 cycles
    output logic [9:0]                 raster_x,
    output logic [8:0]                 raster_line,
    output vic_types_pkg::line_phase_t line_phase,
    output vic_types_pkg::vic_chip_t   chip_cur,     // chip of the running frame
    output logic                       hsync_win,
    output logic                       x_visible
);

logic [1:0]                 div;         // dot divider
logic                       line_wrap;   // last dot of the line
logic                       frame_wrap;  // last dot of the frame
logic [9:0]                 x_next;
logic [8:0]                 line_next;
vic_types_pkg::line_phase_t phase_next;

// ---------------------------------------------------------------------------
// dot enable, fires on the 4th cycle out of reset
// ---------------------------------------------------------------------------
always_ff @(posedge clk_dot4x) begin
    if (!rst_n) begin
        div    <= 2'd0;
        dot_en <= 1'b0;
    end else begin
        div    <= (div == 2'(vic_timing_pkg::DOT_DIV - 1)) ? 2'd0 : div + 2'd1;
        dot_en <= (div == 2'(vic_timing_pkg::DOT_DIV - 2)); // registered, so one early
    end
end

// next raster position and line class
always_comb begin
    line_wrap  = (raster_x == vic_timing_pkg::dots_per_line(chip_cur) - 10'd1);
    frame_wrap = line_wrap &&
                 (raster_line == vic_timing_pkg::lines_per_frame(chip_cur) - 9'd1);
    x_next     = line_wrap ? 10'd0 : raster_x + 10'd1;
    if (frame_wrap)
        line_next = 9'd0;
    else if (line_wrap)
        line_next = raster_line + 9'd1;
    else
        line_next = raster_line;

    phase_next = line_phase;
    if (frame_wrap) begin
        phase_next = vic_types_pkg::LINE_VISIBLE;
    end else if (line_wrap) begin
        case (line_phase)
            vic_types_pkg::LINE_VISIBLE:
                if (line_next == vic_timing_pkg::vis_lines(chip_cur))
                    phase_next = vic_types_pkg::LINE_BORDER;
            vic_types_pkg::LINE_BORDER:   // also after vsync, until the frame wraps
                if (line_next == vic_timing_pkg::vsync_start(chip_cur))
                    phase_next = vic_types_pkg::LINE_VSYNC;
            vic_types_pkg::LINE_VSYNC:
                if (line_next == vic_timing_pkg::vsync_start(chip_cur) +
                                 9'(vic_timing_pkg::VSYNC_LINES))
                    phase_next = vic_types_pkg::LINE_BORDER;
            default:
                phase_next = vic_types_pkg::LINE_VISIBLE;
        endcase
    end
end

// ---------------------------------------------------------------------------
// raster registers, decodes are registered with the values they describe
// ---------------------------------------------------------------------------
always_ff @(posedge clk_dot4x) begin
    if (!rst_n) begin
        raster_x    <= 10'd0;
        raster_line <= 9'd0;
        line_phase  <= vic_types_pkg::LINE_VISIBLE;
        chip_cur    <= chip;
        hsync_win   <= 1'b0;
        x_visible   <= 1'b1;   // x = 0 is visible
    end else if (dot_en) begin
        raster_x    <= x_next;
        raster_line <= line_next;
        line_phase  <= phase_next;
        if (frame_wrap)
            chip_cur <= chip;  // new standard only at 0,0
        hsync_win <= (x_next >= 10'(vic_timing_pkg::HSYNC_START)) &&
                     (x_next <  10'(vic_timing_pkg::HSYNC_START + vic_timing_pkg::HSYNC_DOTS));
        x_visible <= (x_next < 10'(vic_timing_pkg::VIS_DOTS));
    end
end

endmodule : vic_timing_ctrl

/* hdl/comp_sync.sv */
`timescale 1ns/10ps

module comp_sync (
    input  logic                       clk_dot4x,
    input  logic                       rst_n,
    input  logic                       dot_en,
    input  vic_types_pkg::line_phase_t line_phase,
    input  logic                       hsync_win,
    input  logic                       x_visible,
    input  vic_types_pkg::vic_color    pixel_color3,
    output logic                       csync,
    output vic_types_pkg::vic_color    pixel_color4
);

logic in_vsync;  // inverted sync on vsync lines
logic show_pix;  // pixel area of a visible line

assign in_vsync = (line_phase == vic_types_pkg::LINE_VSYNC);
assign show_pix = (line_phase == vic_types_pkg::LINE_VISIBLE) && x_visible;

// ---------------------------------------------------------------------------
// csync follows the window every cycle, pixel only moves on dot_en
// ---------------------------------------------------------------------------
always_ff @(posedge clk_dot4x) begin
    if (!rst_n) begin
        csync        <= 1'b1;
        pixel_color4 <= vic_types_pkg::COL_BLACK;
    end else begin
        csync <= in_vsync ? hsync_win : ~hsync_win; // low in window, or outside it
        if (dot_en)
            pixel_color4 <= show_pix ? pixel_color3 : vic_types_pkg::COL_BLACK;
    end
end

endmodule : comp_sync

/* hdl/vga_sync.sv */
`timescale 1ns/10ps

module vga_sync (
    input  logic                       clk_dot4x,
    input  logic                       rst_n,
    input  logic                       dot_en,
    input  logic [9:0]                 raster_x,
    input  vic_types_pkg::vic_chip_t   chip_cur,
    input  vic_types_pkg::line_phase_t line_phase,
    input  vic_types_pkg::vic_color    pixel_color3,
    output logic                       hsync,
    output logic                       vsync,
    output logic                       active,
    output vic_types_pkg::vic_color    pixel_color4
);

// two banks with one filling while the other is shown twice
vic_types_pkg::vic_color    line_buf [0:1][0:vic_timing_pkg::VIS_DOTS-1];

logic                       wr_bank;
logic                       src_end;     // last dot of the source line
logic [9:0]                 vx;          // doubled x stepping once per 2 cycles
logic                       vx_half;     // which cycle of the output dot
logic                       vx_vis;
logic [8:0]                 rd_addr;
vic_types_pkg::line_phase_t held_phase;  // phase of the line being shown

assign src_end = dot_en && (raster_x == vic_timing_pkg::dots_per_line(chip_cur) - 10'd1);
assign vx_vis  = (vx < 10'(vic_timing_pkg::VIS_DOTS));
assign rd_addr = vx[8:0];

// ---------------------------------------------------------------------------
// line buffer write for visible dots only
// ---------------------------------------------------------------------------
always_ff @(posedge clk_dot4x) begin
    if (dot_en && (raster_x < 10'(vic_timing_pkg::VIS_DOTS)))
        line_buf[wr_bank][raster_x[8:0]] <= pixel_color3;
end

// bank swap and doubled x realigned at every source line end
always_ff @(posedge clk_dot4x) begin
    if (!rst_n) begin
        wr_bank    <= 1'b0;
        held_phase <= vic_types_pkg::LINE_BORDER;  // nothing buffered yet
        vx         <= 10'd0;
        vx_half    <= 1'b0;
    end else if (src_end) begin
        wr_bank    <= ~wr_bank;
        held_phase <= line_phase;
        vx         <= 10'd0;
        vx_half    <= 1'b0;
    end else begin
        vx_half <= ~vx_half;
        if (vx_half)
            vx <= (vx == vic_timing_pkg::dots_per_line(chip_cur) - 10'd1) ? 10'd0
                                                                        : vx + 10'd1;
    end
end

// ---------------------------------------------------------------------------
// sync and pixel out of the shown bank
// ---------------------------------------------------------------------------
always_ff @(posedge clk_dot4x) begin
    if (!rst_n) begin
        hsync        <= 1'b1;
        vsync        <= 1'b1;
        active       <= 1'b0;
        pixel_color4 <= vic_types_pkg::COL_BLACK;
    end else begin
        hsync  <= !((vx >= 10'(vic_timing_pkg::HSYNC_START)) &&
                    (vx <  10'(vic_timing_pkg::HSYNC_START + vic_timing_pkg::HSYNC_DOTS)));
        vsync  <= (held_phase != vic_types_pkg::LINE_VSYNC);  // both output lines
        active <= vx_vis && (held_phase == vic_types_pkg::LINE_VISIBLE);
        if (vx_vis && (held_phase == vic_types_pkg::LINE_VISIBLE))
            pixel_color4 <= line_buf[~wr_bank][rd_addr];
        else
            pixel_color4 <= vic_types_pkg::COL_BLACK;
    end
end

endmodule : vga_sync

/* hdl/color_palette.sv */
`timescale 1ns/10ps

module color_palette (
    input  logic                    clk_dot4x,
    input  logic                    rst_n,
    input  logic                    is_composite,  // high picks composite pixel
    input  vic_types_pkg::vic_color pixel_comp,
    input  vic_types_pkg::vic_color pixel_vga,
    output logic [2:0]              red,
    output logic [2:0]              green,
    output logic [2:0]              blue
);

vic_types_pkg::vic_color sel;
logic [8:0]              rgb;  // {r,g,b}, 3 bits each

assign sel = is_composite ? pixel_comp : pixel_vga;

// ---------------------------------------------------------------------------
// vic-ii colours at 3 bits per gun
// ---------------------------------------------------------------------------
always_comb begin
    case (sel)
        vic_types_pkg::COL_BLACK:       rgb = {3'd0, 3'd0, 3'd0};
        vic_types_pkg::COL_WHITE:       rgb = {3'd7, 3'd7, 3'd7};
        vic_types_pkg::COL_RED:         rgb = {3'd4, 3'd1, 3'd1};
        vic_types_pkg::COL_CYAN:        rgb = {3'd3, 3'd6, 3'd6};
        vic_types_pkg::COL_PURPLE:      rgb = {3'd4, 3'd1, 3'd5};
        vic_types_pkg::COL_GREEN:       rgb = {3'd2, 3'd5, 3'd2};
        vic_types_pkg::COL_BLUE:        rgb = {3'd1, 3'd1, 3'd5};
        vic_types_pkg::COL_YELLOW:      rgb = {3'd6, 3'd7, 3'd3};
        vic_types_pkg::COL_ORANGE:      rgb = {3'd4, 3'd2, 3'd0};
        vic_types_pkg::COL_BROWN:       rgb = {3'd2, 3'd1, 3'd0};
        vic_types_pkg::COL_LIGHT_RED:   rgb = {3'd6, 3'd3, 3'd3};
        vic_types_pkg::COL_DARK_GREY:   rgb = {3'd2, 3'd2, 3'd2};
        vic_types_pkg::COL_GREY:        rgb = {3'd3, 3'd3, 3'd3};
        vic_types_pkg::COL_LIGHT_GREEN: rgb = {3'd5, 3'd7, 3'd4};
        vic_types_pkg::COL_LIGHT_BLUE:  rgb = {3'd3, 3'd3, 3'd7};
        vic_types_pkg::COL_LIGHT_GREY:  rgb = {3'd5, 3'd5, 3'd5};
        default:                        rgb = 9'd0;
    endcase
end

// one register stage to the pins
always_ff @(posedge clk_dot4x) begin
    if (!rst_n) begin
        red   <= 3'd0;
        green <= 3'd0;
        blue  <= 3'd0;
    end else begin
        red   <= rgb[8:6];
        green <= rgb[5:3];
        blue  <= rgb[2:0];
    end
end

endmodule : color_palette

/* hdl/vic_video_top.sv */
`timescale 1ns/10ps

module vic_video_top (
    input  logic                     clk_dot4x,
    input  logic                     rst_n,
    input  vic_types_pkg::vic_chip_t chip,
    input  logic                     is_composite,  // high composite, low vga/hdmi
    input  vic_types_pkg::vic_color  pixel_color3,
    output logic [9:0]               raster_x,
    output logic [8:0]               raster_line,
    output logic                     csync,
    output logic                     hsync,
    output logic                     vsync,
    output logic                     active,
    output logic [2:0]               red,
    output logic [2:0]               green,
    output logic [2:0]               blue
);

logic                       dot_en;
vic_types_pkg::line_phase_t line_phase;
vic_types_pkg::vic_chip_t   chip_cur;
logic                       hsync_win;
logic                       x_visible;
vic_types_pkg::vic_color    pixel_color4_comp;
vic_types_pkg::vic_color    pixel_color4_vga;

// ---------------------------------------------------------------------------
// raster timing
// ---------------------------------------------------------------------------
vic_timing_ctrl u_timing (
    .clk_dot4x(clk_dot4x), .rst_n(rst_n), .chip(chip),
    .dot_en(dot_en), .raster_x(raster_x), .raster_line(raster_line),
    .line_phase(line_phase), .chip_cur(chip_cur),
    .hsync_win(hsync_win), .x_visible(x_visible)
);

// composite path
comp_sync u_comp_sync (
    .clk_dot4x(clk_dot4x), .rst_n(rst_n), .dot_en(dot_en),
    .line_phase(line_phase), .hsync_win(hsync_win), .x_visible(x_visible),
    .pixel_color3(pixel_color3),
    .csync(csync), .pixel_color4(pixel_color4_comp)
);

// vga/hdmi path, line doubled
vga_sync u_vga_sync (
    .clk_dot4x(clk_dot4x), .rst_n(rst_n), .dot_en(dot_en),
    .raster_x(raster_x), .chip_cur(chip_cur), .line_phase(line_phase),
    .pixel_color3(pixel_color3),
    .hsync(hsync), .vsync(vsync), .active(active),
    .pixel_color4(pixel_color4_vga)
);

color_palette u_palette (
    .clk_dot4x(clk_dot4x), .rst_n(rst_n), .is_composite(is_composite),
    .pixel_comp(pixel_color4_comp), .pixel_vga(pixel_color4_vga),
    .red(red), .green(green), .blue(blue)
);

endmodule : vic_video_top

/* tests/tb_vic_video.sv */
`timescale 1ns/10ps

module tb_vic_video;

localparam int CLK_PERIOD  = 40;      // ns
localparam int VIS_DOTS    = 384;
localparam int HSYNC_START = 400;
localparam int HSYNC_DOTS  = 40;
localparam int VSYNC_LINES = 3;
localparam int FRAME_LIMIT = 700000;  // cycle limit above the longest frame

logic                     clk_dot4x;
logic                     rst_n;
vic_types_pkg::vic_chip_t chip;
logic                     is_composite;
vic_types_pkg::vic_color  pixel_color3;
logic [9:0]               raster_x;
logic [8:0]               raster_line;
logic                     csync;
logic                     hsync;
logic                     vsync;
logic                     active;
logic [2:0]               red;
logic [2:0]               green;
logic [2:0]               blue;

integer seed;
string  cur_test;
int     test_errs;
int     tests_run;
int     tests_failed;
int     total_errs;
bit     timed_out;

initial begin
    clk_dot4x = 1'b0;
    forever #(CLK_PERIOD / 2) clk_dot4x = ~clk_dot4x;
end

vic_video_top UUT (
    .clk_dot4x(clk_dot4x), .rst_n(rst_n), .chip(chip),
    .is_composite(is_composite), .pixel_color3(pixel_color3),
    .raster_x(raster_x), .raster_line(raster_line),
    .csync(csync), .hsync(hsync), .vsync(vsync), .active(active),
    .red(red), .green(green), .blue(blue)
);

// ----------------------------------------------------------------------------
// reference model of the raster geometry and palette
// ----------------------------------------------------------------------------
function automatic int line_length(vic_types_pkg::vic_chip_t c);
    return (c == vic_types_pkg::CHIP_6569) ? 504 : 520;  // dots per line
endfunction

function automatic int frame_length(vic_types_pkg::vic_chip_t c);
    return (c == vic_types_pkg::CHIP_6569) ? 312 : 263;  // lines per frame
endfunction

function automatic int visible_lines(vic_types_pkg::vic_chip_t c);
    return (c == vic_types_pkg::CHIP_6569) ? 284 : 234;
endfunction

function automatic int vsync_first_line(vic_types_pkg::vic_chip_t c);
    return (c == vic_types_pkg::CHIP_6569) ? 300 : 240;
endfunction

// csync level for a dot is low in the window and inverted on vsync lines
function automatic logic csync_level(int x, int line, vic_types_pkg::vic_chip_t c);
    logic win;
    logic vs;
    win = (x >= HSYNC_START) && (x < HSYNC_START + HSYNC_DOTS);
    vs  = (line >= vsync_first_line(c)) && (line < vsync_first_line(c) + VSYNC_LINES);
    return vs ? win : !win;
endfunction

function automatic logic [8:0] palette_rgb(logic [3:0] idx);
    case (idx)                           // {r,g,b} in octal with one digit per gun
        4'd0:    return 9'o000;
        4'd1:    return 9'o777;
        4'd2:    return 9'o411;
        4'd3:    return 9'o366;
        4'd4:    return 9'o415;
        4'd5:    return 9'o252;
        4'd6:    return 9'o115;
        4'd7:    return 9'o673;
        4'd8:    return 9'o420;
        4'd9:    return 9'o210;
        4'd10:   return 9'o633;
        4'd11:   return 9'o222;
        4'd12:   return 9'o333;
        4'd13:   return 9'o574;
        4'd14:   return 9'o337;
        default: return 9'o555;
    endcase
endfunction

// ----------------------------------------------------------------------------
// bookkeeping
// ----------------------------------------------------------------------------
task automatic start_test(string name);
    cur_test  = name;
    test_errs = 0;
endtask

task automatic end_test();
    tests_run++;
    total_errs += test_errs;
    if (test_errs == 0) begin
        $display("test %s: passed", cur_test);
    end else begin
        tests_failed++;
        $display("test %s: failed with %0d errors", cur_test, test_errs);
    end
endtask

task automatic report_mismatch(string what, int expected, int actual);
    test_errs++;
    $display("Error %s: %s expected %0d actual %0d", cur_test, what, expected, actual);
endtask

// stops on the first sample of raster 0,0 after any other position
task automatic wait_frame_start();
    int n;
    bit seen_other;
    n          = 0;
    seen_other = 0;
    while (!timed_out) begin
        @(negedge clk_dot4x);
        if (raster_x != 10'd0 || raster_line != 9'd0)
            seen_other = 1;
        else if (seen_other)
            break;
        n++;
        if (n > FRAME_LIMIT) begin
            $display("timeout: no frame start seen within %0d cycles", FRAME_LIMIT);
            timed_out = 1;
        end
    end
endtask

// ----------------------------------------------------------------------------
// one frame entered and left on the frame start sample
// ----------------------------------------------------------------------------
task automatic scan_frame(string name, vic_types_pkg::vic_chip_t fchip, logic comp,
                          bit do_switch);
    int          n;
    int          cx;
    int          cl;
    int          px;
    int          pl;
    int          max_x;
    int          max_line;
    int          inv_lines;
    int          hs_pulses;
    int          vs_lines;
    int          act_lines;
    int          act_run;
    logic        prev_hs;
    logic        prev_act;
    logic        want_cs;
    logic [31:0] rnd;
    logic [8:0]  exp_rgb;
    logic [8:0]  got_rgb;
    logic [8:0]  mid_rgb;
    bit          done;
    start_test(name);
    rnd          = $random(seed);
    pixel_color3 = vic_types_pkg::vic_color'((rnd[3:0] == 4'd0) ? 4'd1 : rnd[3:0]);
    is_composite = comp;
    exp_rgb      = palette_rgb(pixel_color3);
    px           = line_length(fchip) - 1;   // last dot of the previous frame
    pl           = frame_length(fchip) - 1;
    max_x        = 0;
    max_line     = 0;
    inv_lines    = 0;
    hs_pulses    = 0;
    vs_lines     = 0;
    act_lines    = 0;
    act_run      = 0;
    prev_hs      = 1'b1;
    prev_act     = 1'b0;
    n            = 0;
    done         = 0;
    while (!done && !timed_out) begin
        cx      = int'(raster_x);
        cl      = int'(raster_line);
        got_rgb = {red, green, blue};
        if (cx > max_x)
            max_x = cx;
        if (cl > max_line)
            max_line = cl;
        want_cs = csync_level(px, pl, fchip);  // csync is one cycle behind
        if (csync !== want_cs)
            report_mismatch("csync", want_cs, csync);
        if (cx == HSYNC_START + 20 && px != cx && csync)
            inv_lines++;                       // high mid window on an inverted line
        if (comp && cx == VIS_DOTS / 2 && px != cx) begin
            mid_rgb = (cl < visible_lines(fchip)) ? exp_rgb : 9'd0;
            if (got_rgb != mid_rgb)
                report_mismatch("composite rgb mid line", mid_rgb, got_rgb);
        end
        if (comp && cx == 450 && px != cx && got_rgb != 9'd0)
            report_mismatch("composite rgb right border", 0, got_rgb);
        // vga side
        if (prev_hs && !hsync) begin
            hs_pulses++;
            if (!vsync)
                vs_lines++;
        end
        if (active) begin
            if (!prev_act)
                act_lines++;
            act_run++;
            if (!comp && act_run == VIS_DOTS && got_rgb != exp_rgb)
                report_mismatch("vga rgb mid line", exp_rgb, got_rgb);
        end else if (prev_act) begin
            if (act_run != 2 * VIS_DOTS)
                report_mismatch("active length", 2 * VIS_DOTS, act_run);
            act_run = 0;
        end
        if (do_switch && cl == 100)            // takes effect at the next frame
            chip = (fchip == vic_types_pkg::CHIP_6569) ? vic_types_pkg::CHIP_6567R8
                                                       : vic_types_pkg::CHIP_6569;
        px       = cx;
        pl       = cl;
        prev_hs  = hsync;
        prev_act = active;
        @(negedge clk_dot4x);
        n++;
        if (raster_x == 10'd0 && raster_line == 9'd0 && (px != 0 || pl != 0)) begin
            done = 1;
        end else if (n > FRAME_LIMIT) begin
            $display("timeout: frame of test %s did not end within %0d cycles",
                     name, FRAME_LIMIT);
            test_errs++;
            timed_out = 1;
        end
    end
    if (!timed_out) begin
        if (max_x + 1 != line_length(fchip))
            report_mismatch("dots per line", line_length(fchip), max_x + 1);
        if (max_line + 1 != frame_length(fchip))
            report_mismatch("lines per frame", frame_length(fchip), max_line + 1);
        if (inv_lines != VSYNC_LINES)
            report_mismatch("inverted csync lines", VSYNC_LINES, inv_lines);
        if (hs_pulses != 2 * frame_length(fchip))
            report_mismatch("hsync pulses", 2 * frame_length(fchip), hs_pulses);
        if (vs_lines != 2 * VSYNC_LINES)
            report_mismatch("vsync lines", 2 * VSYNC_LINES, vs_lines);
        if (act_lines != 2 * visible_lines(fchip))
            report_mismatch("active lines", 2 * visible_lines(fchip), act_lines);
    end
    end_test();
endtask

// ----------------------------------------------------------------------------
// test sequence
// ----------------------------------------------------------------------------
initial begin
    seed         = 53;
    tests_run    = 0;
    tests_failed = 0;
    total_errs   = 0;
    timed_out    = 0;
    rst_n        = 1'b0;
    chip         = vic_types_pkg::CHIP_6567R8;
    is_composite = 1'b1;
    pixel_color3 = vic_types_pkg::COL_BLACK;
    repeat (3) @(posedge clk_dot4x);
    @(negedge clk_dot4x);
    rst_n = 1'b1;

    start_test("reset");
    @(negedge clk_dot4x);                      // one cycle out of reset before the first dot
    if (csync !== 1'b1)
        report_mismatch("csync", 1, csync);
    if (hsync !== 1'b1)
        report_mismatch("hsync", 1, hsync);
    if (vsync !== 1'b1)
        report_mismatch("vsync", 1, vsync);
    if (active !== 1'b0)
        report_mismatch("active", 0, active);
    if ({red, green, blue} !== 9'd0)
        report_mismatch("rgb", 0, {red, green, blue});
    if (raster_x !== 10'd0 || raster_line !== 9'd0)
        report_mismatch("raster position", 0, {raster_line, raster_x});
    end_test();

    wait_frame_start();                        // skip the frame started by reset
    if (!timed_out)
        scan_frame("ntsc_composite", vic_types_pkg::CHIP_6567R8, 1'b1, 1'b0);
    if (!timed_out)
        scan_frame("ntsc_vga_chip_switch", vic_types_pkg::CHIP_6567R8, 1'b0, 1'b1);
    if (!timed_out)
        scan_frame("pal_composite", vic_types_pkg::CHIP_6569, 1'b1, 1'b0);
    if (!timed_out)
        scan_frame("pal_vga", vic_types_pkg::CHIP_6569, 1'b0, 1'b0);

    $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed,
             total_errs);
    if (timed_out || tests_failed != 0)
        $display("Finished with errors");
    else
        $display("Finished with no errors");
    $finish;
end

endmodule : tb_vic_video

/* build.f */
hdl/vic_types_pkg.sv
hdl/vic_timing_pkg.sv
hdl/vic_timing_ctrl.sv
hdl/comp_sync.sv
hdl/vga_sync.sv
hdl/color_palette.sv
hdl/vic_video_top.sv
tests/tb_vic_video.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --timescale 1ns/10ps -Wno-fatal
TOP       = tb_vic_video
FILELIST  = build.f
PASS_MSG  = Finished with no errors

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf obj_dir
